//--- Bender.yml
package:
  name: stepper

sources:
  - hdl/stepper_pkg.sv
  - hdl/debounce.sv
  - hdl/motor_regs.sv
  - hdl/step_gen.sv
  - hdl/spi_link.sv
  - hdl/stepper.sv
  - target: test
    files:
      - verif/tb_stepper.sv

//--- flist.f
hdl/stepper_pkg.sv
hdl/debounce.sv
hdl/motor_regs.sv
hdl/step_gen.sv
hdl/spi_link.sv
hdl/stepper.sv
verif/tb_stepper.sv

//--- hdl/debounce.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// button debounce filter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module debounce #(
  parameter int unsigned DEBOUNCE_CYCLES = 250000
) (
  input  logic clk_in,
  input  logic rst,
  input  logic in,
  output logic out
);

  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  // two flop synchronizer for the raw pin
  logic             sync_q1;
  logic             sync_q2;
  // cycles the new level has held so far
  logic [CNT_W-1:0] stable_cnt;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      sync_q1    <= 1'b0;
      sync_q2    <= 1'b0;
      stable_cnt <= '0;
      out        <= 1'b0;
    end else begin
      sync_q1 <= in;
      sync_q2 <= sync_q1;
      if (sync_q2 == out) begin
        // no change pending, or a bounce went back
        stable_cnt <= '0;
      end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        // held long enough, accept it
        out        <= sync_q2;
        stable_cnt <= '0;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/motor_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// motion register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module motor_regs import stepper_pkg::*; (
  input  logic               clk_in,
  input  logic               rst,
  input  io_req_t            req,
  output logic [31:0]        rdata,
  output motor_cfg_t         cfg,
  input  logic signed [15:0] position,
  input  logic               estop,
  output logic               spi_start,
  output spi_frame_u         spi_tx,
  input  logic               spi_busy,
  input  logic               spi_done,
  input  spi_frame_u         spi_rx
);

  ctrl_t       ctrl_q;
  logic [31:0] period_q;
  // last completed reply
  spi_frame_u  rx_q;
  status_t     status_word;

  logic wr_en;
  logic rd_en;
  logic spi_accept;

  assign wr_en = req.en & req.we;
  assign rd_en = req.en & ~req.we;

  // link must be idle and no start already in flight
  assign spi_accept = wr_en && (req.addr[3:2] == REG_SPI[3:2]) && !spi_busy && !spi_start;

  always_comb begin
    status_word            = '0;
    status_word.spi_busy   = spi_busy;
    status_word.estop      = estop;
    status_word.spi_status = rx_q.rx.status;
    status_word.position   = position;
  end

  // software visible registers
  always_ff @(posedge clk_in) begin
    if (rst) begin
      ctrl_q   <= '0;
      period_q <= '0;
    end else if (wr_en) begin
      if (req.addr[3:2] == REG_CTRL[3:2]) begin
        ctrl_q <= ctrl_t'(req.wdata);
      end
      if (req.addr[3:2] == REG_PERIOD[3:2]) begin
        period_q <= req.wdata;
      end
    end
  end

  // registered copy toward the step generator
  always_ff @(posedge clk_in) begin
    if (rst) begin
      cfg <= '0;
    end else begin
      cfg.drv_en <= ctrl_q.drv_en;
      cfg.dir    <= ctrl_q.dir;
      cfg.run    <= ctrl_q.run;
      cfg.period <= period_q[15:0];
    end
  end

  // start pulse, one cycle wide
  always_ff @(posedge clk_in) begin
    if (rst) begin
      spi_start <= 1'b0;
    end else begin
      spi_start <= spi_accept;
    end
  end

  // frame fields come from CTRL plus the written word
  always_ff @(posedge clk_in) begin
    if (spi_accept) begin
      spi_tx.tx.write <= ctrl_q.spi_write;
      spi_tx.tx.addr  <= ctrl_q.spi_addr;
      spi_tx.tx.data  <= req.wdata;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      rx_q <= '0;
    end else if (spi_done) begin
      rx_q <= spi_rx;
    end
  end

  // read port, data one cycle after the strobe
  always_ff @(posedge clk_in) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd_en) begin
      case (req.addr[3:2])
        REG_CTRL[3:2]:   rdata <= ctrl_q;
        REG_PERIOD[3:2]: rdata <= period_q;
        REG_SPI[3:2]:    rdata <= rx_q.rx.data;
        default:         rdata <= status_word;
      endcase
    end
  end

  // no new frame may start on top of a running one
  a_no_start_busy: assert property (
    @(posedge clk_in) disable iff (rst) $rose(spi_start) |-> !spi_busy
  );

endmodule

`default_nettype wire

//--- hdl/spi_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// driver SPI master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_link import stepper_pkg::*; #(
  parameter int unsigned SPI_DIV = 4
) (
  input  logic       clk_in,
  input  logic       rst,
  input  logic       start,
  input  spi_frame_u tx,
  output logic       busy,
  output logic       done,
  output spi_frame_u rx,
  output logic       sck,
  output logic       cs_n,
  output logic       mosi,
  input  logic       miso
);

  localparam int DIV_W = (2 * SPI_DIV > 1) ? $clog2(2 * SPI_DIV) : 1;
  localparam int BIT_W = $clog2(SPI_FRAME_BITS);

  // position inside one bit time
  logic [DIV_W-1:0]          div_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic [SPI_FRAME_BITS-1:0] tx_shift;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      cs_n    <= 1'b1;
      sck     <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          // select and first falling sck together
          busy    <= 1'b1;
          cs_n    <= 1'b0;
          sck     <= 1'b0;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (div_cnt == DIV_W'(SPI_DIV - 1)) begin
        // mid bit, slave data is settled
        sck     <= 1'b1;
        div_cnt <= div_cnt + 1'b1;
      end else if (div_cnt == DIV_W'(2 * SPI_DIV - 1)) begin
        div_cnt <= '0;
        if (bit_cnt == BIT_W'(SPI_FRAME_BITS - 1)) begin
          // last bit done, release the chip
          busy <= 1'b0;
          done <= 1'b1;
          cs_n <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          sck     <= 1'b0;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // shift registers, loaded at start
  always_ff @(posedge clk_in) begin
    if (!busy && start) begin
      tx_shift <= tx;
    end else if (busy && div_cnt == DIV_W'(2 * SPI_DIV - 1)) begin
      tx_shift <= tx_shift << 1;
    end
    // capture on the rising sck edge
    if (busy && div_cnt == DIV_W'(SPI_DIV - 1)) begin
      rx <= {rx[SPI_FRAME_BITS-2:0], miso};
    end
  end

  // msb leads, line low while deselected
  assign mosi = ~cs_n & tx_shift[SPI_FRAME_BITS-1];

  // mode 3 idles with sck high
  a_sck_idle_high: assert property (
    @(posedge clk_in) disable iff (rst) cs_n |-> sck
  );

endmodule

`default_nettype wire

//--- hdl/step_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// step pulse generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module step_gen import stepper_pkg::*; (
  input  logic               clk_in,
  input  logic               rst,
  input  motor_cfg_t         cfg,
  input  logic               estop,
  output logic               step,
  output logic               dir,
  output logic               drv_en_n,
  output logic signed [15:0] position
);

  logic        active;
  // half period after clamping
  logic [15:0] half;
  logic [15:0] half_cnt;
  logic        step_q;
  // pin level one cycle back
  logic        step_d;

  // stepping needs run, an enabled driver and no stop
  assign active = cfg.run & cfg.drv_en & ~estop;

  // below 2 the toggle would stall or race
  assign half = (cfg.period < 16'd2) ? 16'd2 : cfg.period;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      half_cnt <= '0;
      step_q   <= 1'b0;
    end else if (!active) begin
      // park low, counter restarts
      half_cnt <= '0;
      step_q   <= 1'b0;
    end else if (half_cnt == half - 16'd1) begin
      half_cnt <= '0;
      step_q   <= ~step_q;
    end else begin
      half_cnt <= half_cnt + 16'd1;
    end
  end

  // pin drops as soon as stepping stops
  assign step     = step_q & active;
  assign dir      = cfg.dir;
  // stop button overrides software enable
  assign drv_en_n = ~cfg.drv_en | estop;

  // only a rise that reaches the pin moves the motor
  always_ff @(posedge clk_in) begin
    if (rst) begin
      step_d   <= 1'b0;
      position <= '0;
    end else begin
      step_d <= step;
      if (step && !step_d) begin
        if (cfg.dir) begin
          position <= position - 16'sd1;
        end else begin
          position <= position + 16'sd1;
        end
      end
    end
  end

  // while stop stays held, no pulse and no motion
  a_estop_holds: assert property (
    @(posedge clk_in) disable iff (rst) $past(estop) |-> (!step && $stable(position))
  );

endmodule

`default_nettype wire

//--- hdl/stepper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stepper motion block top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stepper import stepper_pkg::*; #(
  parameter int unsigned DEBOUNCE_CYCLES = 250000,
  parameter int unsigned SPI_DIV         = 4
) (
  input  logic        clk_25mhz,
  input  logic        rst,
  input  io_req_t     req,
  output logic [31:0] rdata,
  input  logic        btn_stop,
  output logic        step,
  output logic        dir,
  output logic        drv_en_n,
  output logic        sck,
  output logic        cs_n,
  output logic        mosi,
  input  logic        miso,
  output logic [7:0]  led
);

  logic               estop;
  motor_cfg_t         cfg;
  logic signed [15:0] position;
  logic               spi_start;
  logic               spi_busy;
  logic               spi_done;
  spi_frame_u         spi_tx;
  spi_frame_u         spi_rx;

  // stop button filter
  debounce #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) i_debounce (
    .clk_in(clk_25mhz),
    .rst   (rst),
    .in    (btn_stop),
    .out   (estop)
  );

  motor_regs i_motor_regs (
    .clk_in   (clk_25mhz),
    .rst      (rst),
    .req      (req),
    .rdata    (rdata),
    .cfg      (cfg),
    .position (position),
    .estop    (estop),
    .spi_start(spi_start),
    .spi_tx   (spi_tx),
    .spi_busy (spi_busy),
    .spi_done (spi_done),
    .spi_rx   (spi_rx)
  );

  step_gen i_step_gen (
    .clk_in  (clk_25mhz),
    .rst     (rst),
    .cfg     (cfg),
    .estop   (estop),
    .step    (step),
    .dir     (dir),
    .drv_en_n(drv_en_n),
    .position(position)
  );

  // driver chip configuration port
  spi_link #(
    .SPI_DIV(SPI_DIV)
  ) i_spi_link (
    .clk_in(clk_25mhz),
    .rst   (rst),
    .start (spi_start),
    .tx    (spi_tx),
    .busy  (spi_busy),
    .done  (spi_done),
    .rx    (spi_rx),
    .sck   (sck),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  // low position byte on the board leds
  assign led = position[7:0];

endmodule

`default_nettype wire

//--- hdl/stepper_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stepper motion block types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package stepper_pkg;

  // one processor IO access, strobes plus word
  typedef struct packed {
    logic        en;
    logic        we;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } io_req_t;

  // byte offsets inside the IO window
  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_PERIOD = 4'h4;
  localparam logic [3:0] REG_SPI    = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  // CTRL register layout
  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic        spi_write;
    logic [6:0]  spi_addr;
    logic [4:0]  rsvd_lo;
    logic        run;
    logic        dir;
    logic        drv_en;
  } ctrl_t;

  // handed from register block to step generator
  typedef struct packed {
    logic        drv_en;
    logic        dir;
    logic        run;
    logic [15:0] period;
  } motor_cfg_t;

  // driver chip datagram length
  localparam int SPI_FRAME_BITS = 40;

  // outgoing view, msb first on the wire
  typedef struct packed {
    logic        write;
    logic [6:0]  addr;
    logic [31:0] data;
  } spi_tx_t;

  // reply view, status byte leads
  typedef struct packed {
    logic [7:0]  status;
    logic [31:0] data;
  } spi_rx_t;

  // same shifted word, two meanings
  typedef union packed {
    spi_tx_t tx;
    spi_rx_t rx;
  } spi_frame_u;

  // STATUS read word
  typedef struct packed {
    logic signed [15:0] position;
    logic [7:0]         spi_status;
    logic [5:0]         rsvd;
    logic               estop;
    logic               spi_busy;
  } status_t;

endpackage

`default_nettype wire

//--- verif/tb_stepper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stepper motion block testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_stepper import stepper_pkg::*; ();

  localparam int unsigned DEBOUNCE_CYCLES = 8;
  localparam int unsigned SPI_DIV         = 2;
  localparam int N_REG = 6;
  localparam int N_SPI = 4;
  localparam int N_WIN = 5;
  localparam int MAX_P = 20;
  localparam int FRAME_CYCLES = SPI_FRAME_BITS * 2 * SPI_DIV;
  // register loop, SPI frames, stepping windows and button waits, doubled
  localparam int WATCHDOG_CYCLES = 2 * (N_REG * 30 + (N_SPI + 2) * (FRAME_CYCLES + 60)
      + (N_WIN + 2) * (4 * MAX_P + 100) + 6 * (DEBOUNCE_CYCLES + 10) + 200);

  logic        clk = 1'b0;
  logic        rst;
  io_req_t     req;
  logic [31:0] rdata;
  logic        btn_stop;
  logic        step;
  logic        dir;
  logic        drv_en_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic [7:0]  led;

  // reference model state
  logic [31:0]        lfsr_state;
  ctrl_t              model_ctrl;
  logic [31:0]        model_period;
  spi_frame_u         model_rx;
  logic               model_estop;
  logic signed [15:0] model_pos = '0;
  int                 step_rises = 0;
  logic               step_last = 1'b0;

  // SPI slave model state
  spi_frame_u slave_reply = '0;
  spi_frame_u slave_shift = '0;
  spi_frame_u slave_frame = '0;
  int         slave_frames = 0;
  int         miso_idx = 0;
  logic       sck_last = 1'b1;
  logic       cs_last = 1'b1;

  stepper #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .SPI_DIV        (SPI_DIV)
  ) i_stepper (
    .clk_25mhz(clk),
    .rst      (rst),
    .req      (req),
    .rdata    (rdata),
    .btn_stop (btn_stop),
    .step     (step),
    .dir      (dir),
    .drv_en_n (drv_en_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .led      (led)
  );

  // 25 MHz board clock
  always #20 clk = ~clk;

  // count rising step edges, sign from the dir pin
  always @(posedge clk) begin
    if (rst) begin
      step_last <= 1'b0;
    end else begin
      step_last <= step;
      if (step && !step_last) begin
        step_rises <= step_rises + 1;
        model_pos  <= dir ? model_pos - 16'sd1 : model_pos + 16'sd1;
      end
    end
  end

  // mode 3 slave, edges of sck seen one clock late
  always @(posedge clk) begin
    sck_last <= sck;
    cs_last  <= cs_n;
    if (!cs_n && !sck && sck_last) begin
      // sck fell, present the next reply bit
      miso     <= slave_reply[SPI_FRAME_BITS - 1 - miso_idx];
      miso_idx <= miso_idx + 1;
    end
    if (!cs_n && sck && !sck_last) begin
      slave_shift <= {slave_shift[SPI_FRAME_BITS-2:0], mosi};
    end
    if (cs_n && !cs_last) begin
      // deselect closes the frame
      slave_frame  <= slave_shift;
      slave_frames <= slave_frames + 1;
      miso_idx     <= 0;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_frame(input spi_frame_u got, input spi_frame_u exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_cfg(input motor_cfg_t got, input motor_cfg_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  // strobe for one cycle, write lands on the second edge
  task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    req <= {1'b1, 1'b1, addr, data};
    @(posedge clk);
    req <= '0;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    req <= {1'b1, 1'b0, addr, 32'h0};
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    data = rdata;
  endtask

  function automatic logic [31:0] expected_status();
    status_t s;
    s            = '0;
    s.position   = model_pos;
    s.spi_status = model_rx.rx.status;
    s.estop      = model_estop;
    return s;
  endfunction

  // poll STATUS until the link is idle
  task automatic wait_spi_idle();
    logic [31:0] rd;
    status_t     st;
    int          polls;
    polls       = 0;
    st          = '0;
    st.spi_busy = 1'b1;
    repeat (2) @(posedge clk);
    while (st.spi_busy && polls < FRAME_CYCLES) begin
      bus_read(REG_STATUS, rd);
      st = status_t'(rd);
      polls++;
    end
    if (st.spi_busy) begin
      abort_run("SPI link never dropped busy");
    end
  endtask

  task automatic spi_test(input bit overlap);
    ctrl_t       c;
    spi_frame_u  exp_tx;
    logic [63:0] r;
    logic [31:0] data;
    logic [31:0] rd;
    int          frames_before;
    r = rand_bits(32);
    c = ctrl_t'(r[31:0]);
    c.run = 1'b0;
    r = rand_bits(32);
    data = r[31:0];
    r = rand_bits(40);
    slave_reply = spi_frame_u'(r[39:0]);
    bus_write(REG_CTRL, c);
    model_ctrl = c;
    // what the slave should capture
    exp_tx.tx.write = c.spi_write;
    exp_tx.tx.addr  = c.spi_addr;
    exp_tx.tx.data  = data;
    frames_before = slave_frames;
    bus_write(REG_SPI, data);
    if (overlap) begin
      // lands mid frame, must be dropped
      repeat (3) @(posedge clk);
      bus_write(REG_SPI, ~data);
    end
    wait_spi_idle();
    repeat (4) @(negedge clk);
    check_word(slave_frames - frames_before, 1, "frames seen by slave");
    check_bit(cs_n, 1'b1, "cs_n after transfer");
    check_frame(slave_frame, exp_tx, "mosi frame");
    model_rx = slave_reply;
    bus_read(REG_SPI, rd);
    check_word(rd, model_rx.rx.data, "SPI rx data");
    bus_read(REG_STATUS, rd);
    check_word(rd, expected_status(), "STATUS after SPI");
  endtask

  // run for a random window, measure toggle spacing, then stop
  task automatic step_window(input logic d);
    ctrl_t       c;
    logic [63:0] r;
    logic [31:0] rd;
    logic        prev;
    int          p;
    int          win;
    int          since;
    int          edges;
    r = rand_bits(5);
    p = 2 + int'(r[4:0]) % (MAX_P - 1);
    r = rand_bits(6);
    win = 3 * p + int'(r[5:0]);
    bus_write(REG_PERIOD, p);
    model_period = p;
    c = model_ctrl;
    c.drv_en = 1'b1;
    c.dir    = d;
    c.run    = 1'b1;
    bus_write(REG_CTRL, c);
    model_ctrl = c;
    prev  = 1'b0;
    since = 0;
    edges = 0;
    repeat (win) begin
      @(negedge clk);
      since++;
      if (step !== prev) begin
        if (edges > 0) begin
          check_word(since, p, "step half period");
        end
        edges++;
        since = 0;
      end
      prev = step;
    end
    check_bit(edges >= 2, 1'b1, "two step edges in window");
    c.run = 1'b0;
    bus_write(REG_CTRL, c);
    model_ctrl = c;
    repeat (3) @(negedge clk);
    check_bit(step, 1'b0, "step after run cleared");
    bus_read(REG_STATUS, rd);
    check_word(rd, expected_status(), "STATUS position");
    check_word(led, model_pos[7:0], "led");
  endtask

  task automatic estop_test();
    ctrl_t       c;
    status_t     st;
    logic [31:0] rd;
    int          rises;
    int          waited;
    bus_write(REG_PERIOD, 4);
    model_period = 4;
    c = model_ctrl;
    c.drv_en = 1'b1;
    c.run    = 1'b1;
    bus_write(REG_CTRL, c);
    model_ctrl = c;
    repeat (12) @(posedge clk);
    // bounce too short to pass the filter
    btn_stop <= 1'b1;
    repeat (DEBOUNCE_CYCLES - 3) @(posedge clk);
    btn_stop <= 1'b0;
    repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
    bus_read(REG_STATUS, rd);
    st = status_t'(rd);
    check_bit(st.estop, 1'b0, "estop after short bounce");
    check_bit(drv_en_n, 1'b0, "drv_en_n after short bounce");
    // real press, held past the filter
    @(posedge clk);
    btn_stop <= 1'b1;
    repeat (DEBOUNCE_CYCLES + 6) @(posedge clk);
    model_estop = 1'b1;
    @(negedge clk);
    rises = step_rises;
    check_bit(drv_en_n, 1'b1, "drv_en_n during estop");
    check_bit(step, 1'b0, "step during estop");
    repeat (40) @(negedge clk);
    check_word(step_rises, rises, "step rises during estop");
    bus_read(REG_STATUS, rd);
    check_word(rd, expected_status(), "STATUS during estop");
    @(posedge clk);
    btn_stop <= 1'b0;
    repeat (DEBOUNCE_CYCLES + 6) @(posedge clk);
    model_estop = 1'b0;
    waited = 0;
    while (step_rises == rises && waited < 4 * MAX_P) begin
      @(negedge clk);
      waited++;
    end
    if (step_rises == rises) begin
      abort_run("stepping did not resume after the stop button was released");
    end
    c.run = 1'b0;
    bus_write(REG_CTRL, c);
    model_ctrl = c;
    repeat (3) @(negedge clk);
    bus_read(REG_STATUS, rd);
    check_word(rd, expected_status(), "STATUS after estop release");
  endtask

  initial begin
    ctrl_t       c;
    ctrl_t       prev;
    logic [63:0] r;
    logic [31:0] p;
    logic [31:0] rd;
    rst          = 1'b1;
    req          = '0;
    btn_stop     = 1'b0;
    miso         = 1'b1;
    lfsr_state   = 32'd41;
    model_ctrl   = '0;
    model_period = '0;
    model_rx     = '0;
    model_estop  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // idle pins and cleared registers
    check_bit(step, 1'b0, "step after reset");
    check_bit(drv_en_n, 1'b1, "drv_en_n after reset");
    check_bit(cs_n, 1'b1, "cs_n after reset");
    check_bit(sck, 1'b1, "sck after reset");
    for (int a = 0; a < 4; a++) begin
      bus_read(4'(4 * a), rd);
      check_word(rd, 32'h0, "register after reset");
    end
    repeat (N_REG) begin
      r = rand_bits(32);
      c = ctrl_t'(r[31:0]);
      c.run = 1'b0;
      r = rand_bits(32);
      p = r[31:0];
      prev = model_ctrl;
      bus_write(REG_CTRL, c);
      model_ctrl = c;
      // pins lag the write by one cycle
      @(negedge clk);
      check_bit(dir, prev.dir, "dir before cfg update");
      check_bit(drv_en_n, !prev.drv_en, "drv_en_n before cfg update");
      @(negedge clk);
      check_bit(dir, c.dir, "dir after CTRL write");
      check_bit(drv_en_n, !c.drv_en, "drv_en_n after CTRL write");
      bus_write(REG_PERIOD, p);
      model_period = p;
      bus_read(REG_CTRL, rd);
      check_word(rd, model_ctrl, "CTRL readback");
      bus_read(REG_PERIOD, rd);
      check_word(rd, model_period, "PERIOD readback");
      // word handed on to the step generator
      check_cfg(i_stepper.cfg,
                {model_ctrl.drv_en, model_ctrl.dir, model_ctrl.run, model_period[15:0]},
                "cfg to step generator");
    end
    repeat (N_SPI) begin
      spi_test(1'b0);
    end
    spi_test(1'b1);
    repeat (N_WIN) begin
      r = rand_bits(1);
      step_window(r[0]);
    end
    estop_test();
    $display("Test OK");
    $finish;
  end

  // hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("run hung, no finish after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

`default_nettype wire
